// ==== laser_pkg.sv ====
// RAM port widths, user page erase constants and audio DAC width
`default_nettype none

package laser_pkg;

	// External RAM request port
	localparam int RAM_AW    = 25;    // Byte address width
	localparam int RAM_DW    = 8;     // Data byte width
	localparam int PAGE_BITS = 14;    // Offset inside one 16 KB page

	// User RAM pages cleared on a reset request
	localparam int ERASE_FIRST_PAGE = 3;
	localparam int ERASE_END_PAGE   = 8;    // One past the last user page

	// F14M cycles per eraser write
	// Stands in for the F3M quarter rate clock
	localparam int ERASE_STRIDE = 4;
	localparam int STRIDE_W     = $clog2(ERASE_STRIDE);

	// Sweep bounds as RAM byte addresses
	localparam logic [RAM_AW-1:0] ERASE_START_ADDR =
		RAM_AW'(ERASE_FIRST_PAGE) << PAGE_BITS;    // 0x0C000
	localparam logic [RAM_AW-1:0] ERASE_LAST_ADDR =
		(RAM_AW'(ERASE_END_PAGE) << PAGE_BITS) - 1'b1;    // 0x1FFFF

	// Audio
	localparam int DAC_W = 16;    // DAC word width

endpackage

`default_nettype wire

// ==== laser_sys_ctrl.sv ====
// CPU reset and video blanking registers with the erase start edge detector
`timescale 1ns/1ps
`default_nettype none

module laser_sys_ctrl (
	input  logic F14M,
	input  logic rst,
	input  logic boot_done,      // ROM image loaded
	input  logic downloading,    // Loader busy
	input  logic erasing,        // Eraser busy
	input  logic reset_key,      // Keyboard reset combination
	input  logic power_on,       // Menu power on switch
	input  logic reset_req,      // Menu reset request
	output logic cpu_reset,
	output logic blank,
	output logic erase_start     // One cycle pulse
);

	logic reset_req_q;    // Previous reset_req
	logic blank_next;     // Boot state combination

	// Video off until boot done and while RAM is rewritten
	assign blank_next = ~boot_done | downloading | erasing;

	always_ff @(posedge F14M) begin
		if (rst) begin
			blank       <= 1'b1;    // Hold off until boot
			cpu_reset   <= 1'b1;
			erase_start <= 1'b0;
			reset_req_q <= 1'b0;
		end else begin
			blank       <= blank_next;
			cpu_reset   <= blank_next | reset_key | power_on;    // CPU also held by keys
			erase_start <= reset_req & ~reset_req_q;    // Rising edge only
			reset_req_q <= reset_req;
		end
	end

	// A held request must start only one sweep
	assert property (@(posedge F14M) disable iff (rst) erase_start |=> !erase_start)
		else $error("erase_start high on two consecutive cycles");

endmodule

`default_nettype wire

// ==== ram_eraser.sv ====
// User RAM page eraser with stride and address counters
`timescale 1ns/1ps
`default_nettype none

module ram_eraser import laser_pkg::*; (
	input  logic              F14M,
	input  logic              rst,
	input  logic              erase_start,    // Start pulse from controller
	output logic              erasing,        // Sweep in progress
	output logic              er_wr,          // Write strobe
	output logic [RAM_AW-1:0] er_addr,
	output logic [RAM_DW-1:0] er_data
);

	logic [STRIDE_W-1:0] stride;    // Cycle within one write slot

	// One write per slot on its first cycle
	assign er_wr   = erasing && (stride == '0);
	assign er_data = '0;    // RAM is cleared to zero

	always_ff @(posedge F14M) begin
		if (rst) begin
			erasing <= 1'b0;
			stride  <= '0;
		end else if (!erasing) begin
			stride <= '0;
			if (erase_start) begin
				erasing <= 1'b1;    // Starts on next cycle
			end
		end else begin
			if (stride == STRIDE_W'(ERASE_STRIDE - 1)) begin
				stride <= '0;
			end else begin
				stride <= stride + 1'b1;
			end
			// Done after the last page byte
			if (er_wr && er_addr == ERASE_LAST_ADDR) begin
				erasing <= 1'b0;
			end
		end
	end

	// Address counter
	always_ff @(posedge F14M) begin
		if (!erasing) begin
			er_addr <= ERASE_START_ADDR;    // Preload for next sweep
		end else if (er_wr) begin
			er_addr <= er_addr + 1'b1;
		end
	end

	// Writes stay inside the user pages
	assert property (@(posedge F14M) disable iff (rst)
		er_wr |-> (er_addr >= ERASE_START_ADDR && er_addr <= ERASE_LAST_ADDR))
		else $error("eraser write outside user pages at %h", er_addr);

endmodule

`default_nettype wire

// ==== ram_port_mux.sv ====
// Fixed priority multiplexer of loader, eraser and chip requests onto the RAM port
`timescale 1ns/1ps
`default_nettype none

module ram_port_mux import laser_pkg::*; (
	input  logic              downloading,
	input  logic              dl_wr,
	input  logic [RAM_AW-1:0] dl_addr,
	input  logic [RAM_DW-1:0] dl_data,
	input  logic              erasing,
	input  logic              er_wr,
	input  logic [RAM_AW-1:0] er_addr,
	input  logic [RAM_DW-1:0] er_data,
	input  logic              vdc_wr,
	input  logic              vdc_rd,
	input  logic [RAM_AW-1:0] vdc_addr,
	input  logic [RAM_DW-1:0] vdc_din,
	output logic              ram_wr,
	output logic              ram_rd,
	output logic [RAM_AW-1:0] ram_addr,
	output logic [RAM_DW-1:0] ram_din
);

	typedef enum logic [1:0] {SRC_DL, SRC_ER, SRC_VDC} src_t;

	src_t src;    // Current owner of the port

	// Loader write beats eraser beats chip
	always_comb begin
		if (downloading && dl_wr) begin
			src = SRC_DL;
		end else if (erasing) begin
			src = SRC_ER;
		end else begin
			src = SRC_VDC;
		end
	end

	always_comb begin
		case (src)
			SRC_DL: begin
				ram_wr   = dl_wr;
				ram_rd   = 1'b1;    // Read strobe forced as on the board
				ram_addr = dl_addr;
				ram_din  = dl_data;
			end
			SRC_ER: begin
				ram_wr   = er_wr;
				ram_rd   = 1'b1;
				ram_addr = er_addr;
				ram_din  = er_data;
			end
			default: begin
				ram_wr   = vdc_wr;
				ram_rd   = vdc_rd;
				ram_addr = vdc_addr;
				ram_din  = vdc_din;
			end
		endcase
	end

	// Chip must never write into RAM being cleared
	always_comb begin
		if (erasing && ram_wr) begin
			assert (src != SRC_VDC)
				else $error("chip write forwarded during erase");
		end
	end

endmodule

`default_nettype wire

// ==== audio_out.sv ====
// Cassette input latch, one bit audio mix, DAC words and sigma-delta modulator
`timescale 1ns/1ps
`default_nettype none

module audio_out import laser_pkg::*; (
	input  logic             F14M,
	input  logic             rst,
	input  logic             buzzer,     // Keyboard speaker
	input  logic             casout,     // Tape save line
	input  logic             tape_rx,    // Tape input pin
	output logic [DAC_W-1:0] dac_l,
	output logic [DAC_W-1:0] dac_r,
	output logic             audio_l,    // One bit outputs
	output logic             audio_r
);

	logic             casin;       // Latched tape input
	logic             mix;         // Combined one bit sound
	logic [DAC_W-1:0] dac_word;
	logic [DAC_W-1:0] acc;         // Modulator accumulator
	logic [DAC_W:0]   sum;         // Accumulator plus carry
	logic             pdm_out;

	// Tape input is inverted on the board
	always_ff @(posedge F14M) begin
		casin <= ~tape_rx;
	end

	// Tape monitor on top of the buzzer
	assign mix = buzzer ^ casin ^ ~casout;

	// Mix bit in the MSB only
	assign dac_word = {mix, {(DAC_W - 1){1'b0}}};
	assign dac_l    = dac_word;
	assign dac_r    = dac_word;

	// First order modulator
	assign sum = {1'b0, acc} + {1'b0, dac_word};

	always_ff @(posedge F14M) begin
		if (rst) begin
			acc     <= '0;
			pdm_out <= 1'b0;
		end else begin
			acc     <= sum[DAC_W-1:0];
			pdm_out <= sum[DAC_W];    // Carry gives pulse density
		end
	end

	// Same stream on both channels
	assign audio_l = pdm_out;
	assign audio_r = pdm_out;

endmodule

`default_nettype wire

// ==== laser_glue_top.sv ====
// Glue top with system controller, RAM eraser, RAM port multiplexer and audio path
`timescale 1ns/1ps
`default_nettype none

module laser_glue_top import laser_pkg::*; (
	input  logic              F14M,
	input  logic              rst,
	// Image loader port
	input  logic              downloading,
	input  logic              dl_wr,
	input  logic [RAM_AW-1:0] dl_addr,
	input  logic [RAM_DW-1:0] dl_data,
	// Boot and reset state
	input  logic              boot_done,
	input  logic              reset_req,
	input  logic              reset_key,
	input  logic              power_on,
	// Custom chip RAM port
	input  logic              vdc_wr,
	input  logic              vdc_rd,
	input  logic [RAM_AW-1:0] vdc_addr,
	input  logic [RAM_DW-1:0] vdc_din,
	// Sound sources
	input  logic              buzzer,
	input  logic              casout,
	input  logic              tape_rx,
	// Shared RAM request port
	output logic              ram_wr,
	output logic              ram_rd,
	output logic [RAM_AW-1:0] ram_addr,
	output logic [RAM_DW-1:0] ram_din,
	output logic              cpu_reset,
	output logic              blank,
	output logic              erasing,
	output logic [DAC_W-1:0]  dac_l,
	output logic [DAC_W-1:0]  dac_r,
	output logic              audio_l,
	output logic              audio_r
);

	logic              erase_start;    // Controller to eraser
	logic              er_wr;
	logic [RAM_AW-1:0] er_addr;
	logic [RAM_DW-1:0] er_data;

	laser_sys_ctrl sys_ctrl (
		.F14M        ( F14M        ),
		.rst         ( rst         ),
		.boot_done   ( boot_done   ),
		.downloading ( downloading ),
		.erasing     ( erasing     ),
		.reset_key   ( reset_key   ),
		.power_on    ( power_on    ),
		.reset_req   ( reset_req   ),
		.cpu_reset   ( cpu_reset   ),
		.blank       ( blank       ),
		.erase_start ( erase_start )
	);

	ram_eraser eraser (
		.F14M        ( F14M        ),
		.rst         ( rst         ),
		.erase_start ( erase_start ),
		.erasing     ( erasing     ),
		.er_wr       ( er_wr       ),
		.er_addr     ( er_addr     ),
		.er_data     ( er_data     )
	);

	ram_port_mux port_mux (
		.downloading ( downloading ),
		.dl_wr       ( dl_wr       ),
		.dl_addr     ( dl_addr     ),
		.dl_data     ( dl_data     ),
		.erasing     ( erasing     ),
		.er_wr       ( er_wr       ),
		.er_addr     ( er_addr     ),
		.er_data     ( er_data     ),
		.vdc_wr      ( vdc_wr      ),
		.vdc_rd      ( vdc_rd      ),
		.vdc_addr    ( vdc_addr    ),
		.vdc_din     ( vdc_din     ),
		.ram_wr      ( ram_wr      ),
		.ram_rd      ( ram_rd      ),
		.ram_addr    ( ram_addr    ),
		.ram_din     ( ram_din     )
	);

	audio_out audio (
		.F14M    ( F14M    ),
		.rst     ( rst     ),
		.buzzer  ( buzzer  ),
		.casout  ( casout  ),
		.tape_rx ( tape_rx ),
		.dac_l   ( dac_l   ),
		.dac_r   ( dac_r   ),
		.audio_l ( audio_l ),
		.audio_r ( audio_r )
	);

endmodule

`default_nettype wire

// ==== tb_laser_glue.sv ====
// Testbench with clock, reset, stimulus, reference registers, assertions, watchdog and reporting
`timescale 1ns/1ps
`default_nettype none

module tb_laser_glue import laser_pkg::*; ();

	localparam int SWEEP_WRITES = 81920;    // One byte per write over pages 3 to 7
	localparam logic [RAM_AW-1:0] SWEEP_FIRST = 25'h000C000;
	localparam longint WATCHDOG_NS = (longint'(SWEEP_WRITES) * ERASE_STRIDE + 20000) * 100;

	logic              F14M, rst;
	logic              downloading, dl_wr, boot_done, reset_req, reset_key, power_on;
	logic [RAM_AW-1:0] dl_addr, vdc_addr, ram_addr;
	logic [RAM_DW-1:0] dl_data, vdc_din, ram_din;
	logic              vdc_wr, vdc_rd, buzzer, casout, tape_rx;
	logic              ram_wr, ram_rd, cpu_reset, blank, erasing, audio_l, audio_r;
	logic [DAC_W-1:0]  dac_l, dac_r;

	integer            seed = 32'h0561_1038;
	int                errors, tests_ok, tests_bad, test_mark;
	logic              exp_blank, exp_cpu_reset;    // Expected controller outputs
	logic              tape_q;                      // Tape input one cycle back
	logic [DAC_W-1:0]  exp_dac;
	logic              loader_wins, sweep_done;
	int                sweep_cnt;                   // Eraser writes seen at the RAM port
	logic [RAM_AW-1:0] sweep_addr;                  // Next address the eraser must write

	laser_glue_top DUT (.*);

	always #50 F14M = ~F14M;

	assign loader_wins = downloading && dl_wr;
	assign exp_dac     = {buzzer ^ !tape_q ^ !casout, {(DAC_W - 1){1'b0}}};    // Mix bit on top

	// Expected registered outputs
	always @(posedge F14M) begin
		tape_q <= tape_rx;
		if (rst) begin
			exp_blank     <= 1'b1;
			exp_cpu_reset <= 1'b1;
			sweep_cnt     <= 0;
			sweep_addr    <= SWEEP_FIRST;
		end else begin
			exp_blank     <= !boot_done || downloading || erasing;
			exp_cpu_reset <= !boot_done || downloading || erasing || reset_key || power_on;
			if (erasing && ram_wr && !loader_wins) begin    // Eraser slot reached RAM
				sweep_cnt  <= sweep_cnt + 1;
				sweep_addr <= sweep_addr + RAM_AW'(1);
			end
		end
	end

	assert property (@(posedge F14M) disable iff (rst)
		{blank, cpu_reset} == {exp_blank, exp_cpu_reset})
		else begin
			errors++;
			$display("mismatch blank/cpu_reset: got %h expected %h",
				$sampled({blank, cpu_reset}), $sampled({exp_blank, exp_cpu_reset}));
		end

	// Loader write owns the port
	assert property (@(posedge F14M) disable iff (rst) loader_wins |->
		ram_wr && ram_rd && ram_addr == dl_addr && ram_din == dl_data)
		else begin
			errors++;
			$display("mismatch ram_addr/ram_din on loader write: got %h/%h expected %h/%h",
				$sampled(ram_addr), $sampled(ram_din), $sampled(dl_addr), $sampled(dl_data));
		end

	assert property (@(posedge F14M) disable iff (rst) (!loader_wins && !erasing) |->
		{ram_wr, ram_rd, ram_addr, ram_din} == {vdc_wr, vdc_rd, vdc_addr, vdc_din})
		else begin
			errors++;
			$display("mismatch ram port from chip: got %h expected %h",
				$sampled({ram_wr, ram_rd, ram_addr, ram_din}),
				$sampled({vdc_wr, vdc_rd, vdc_addr, vdc_din}));
		end

	// Sweep order catches a forwarded chip write too
	assert property (@(posedge F14M) disable iff (rst)
		(erasing && ram_wr && !loader_wins) |-> ram_addr == sweep_addr)
		else begin
			errors++;
			$display("mismatch ram_addr during erase: got %h expected %h",
				$sampled(ram_addr), $sampled(sweep_addr));
		end

	assert property (@(posedge F14M) disable iff (rst) (erasing && !loader_wins) |-> ram_din == '0)
		else begin
			errors++;
			$display("mismatch ram_din during erase: got %h expected %h", $sampled(ram_din), 8'h00);
		end

	assert property (@(posedge F14M) disable iff (rst) ($rose(reset_req) && !erasing) |-> ##2 erasing)
		else begin
			errors++;
			$display("erasing did not start two cycles after the reset request");
		end

	assert property (@(posedge F14M) disable iff (rst) {dac_l, dac_r} == {exp_dac, exp_dac})
		else begin
			errors++;
			$display("mismatch dac_l/dac_r: got %h/%h expected %h",
				$sampled(dac_l), $sampled(dac_r), $sampled(exp_dac));
		end

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else begin
			errors++;
			$display("mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic begin_test();
		test_mark = errors;
	endtask

	task automatic end_test(input string name);
		if (errors == test_mark) begin
			tests_ok++;
			$display("test %s: ok", name);
		end else begin
			tests_bad++;
			$display("test %s: %0d errors", name, errors - test_mark);
		end
	endtask

	task automatic drive_chip_random();
		vdc_wr   = 1'($random(seed));
		vdc_rd   = 1'($random(seed));
		vdc_addr = RAM_AW'($random(seed));
		vdc_din  = RAM_DW'($random(seed));
	endtask

	task automatic run_controller();
		begin_test();
		repeat (2) @(negedge F14M);    // Still waiting for boot
		boot_done = 1'b1;
		repeat (2) @(negedge F14M);
		reset_key = 1'b1;    // Single cycle key press
		@(negedge F14M);
		reset_key = 1'b0;
		repeat (2) @(negedge F14M);
		downloading = 1'b1;    // Held loader
		repeat (3) @(negedge F14M);
		downloading = 1'b0;
		power_on    = 1'b1;
		@(negedge F14M);
		power_on = 1'b0;
		repeat (2) @(negedge F14M);
		end_test("controller");
	endtask

	task automatic run_mux();
		begin_test();
		repeat (200) begin    // Loader against chip, eraser idle
			@(negedge F14M);
			downloading = 1'($random(seed));
			dl_wr       = 1'($random(seed));
			dl_addr     = RAM_AW'($random(seed));
			dl_data     = RAM_DW'($random(seed));
			drive_chip_random();
		end
		@(negedge F14M);
		downloading = 1'b0;
		dl_wr       = 1'b0;
		vdc_wr      = 1'b0;
		repeat (2) @(negedge F14M);
		end_test("mux priority");
	endtask

	task automatic run_audio_mix();
		int i;
		begin_test();
		for (i = 0; i < 8; i++) begin
			@(negedge F14M);
			{buzzer, casout, tape_rx} = 3'(i);
			repeat (4) @(negedge F14M);    // Several cycles per combination
		end
		end_test("audio mix");
	endtask

	// Count ones of audio_l and audio_r over 64 cycles once the mix is stable
	task automatic measure_density(input logic b, input logic c, input logic t);
		int ones;
		int ones_r;
		int expected;
		@(negedge F14M);
		buzzer   = b;
		casout   = c;
		tape_rx  = t;
		expected = (b ^ !t ^ !c) ? 32 : 0;    // Half scale word or silence
		repeat (3) @(negedge F14M);
		ones   = 0;
		ones_r = 0;
		repeat (64) begin
			@(negedge F14M);
			ones   += int'(audio_l);
			ones_r += int'(audio_r);
		end
		check_value("audio_l ones", ones, expected);
		check_value("audio_r ones", ones_r, expected);
	endtask

	task automatic run_erase();
		int i;
		begin_test();
		@(negedge F14M);
		reset_req = 1'b1;    // Held high for a single sweep
		i = 0;
		while (!erasing && i < 4) begin
			@(negedge F14M);
			i++;
		end
		if (!erasing) begin
			errors++;
			$display("erasing did not rise after the reset request");
		end else begin
			fork
				while (!sweep_done) begin    // Chip keeps requesting
					@(negedge F14M);
					drive_chip_random();
				end
				begin
					wait (sweep_cnt == 1000);
					@(negedge F14M);    // Between two eraser slots
					downloading = 1'b1;
					dl_wr       = 1'b1;
					dl_addr     = 25'h01F00A5;
					dl_data     = 8'h5A;
					@(negedge F14M);
					downloading = 1'b0;
					dl_wr       = 1'b0;
					reset_req   = 1'b0;
					wait (!erasing);
					repeat (3) @(negedge F14M);    // Blank release after the sweep
					sweep_done = 1'b1;
				end
			join
			vdc_wr = 1'b0;
			check_value("eraser writes", sweep_cnt, SWEEP_WRITES);
		end
		end_test("erase sweep and blanking");
	endtask

	initial begin
		F14M        = 1'b0;
		rst         = 1'b1;
		downloading = 1'b0;
		dl_wr       = 1'b0;
		dl_addr     = '0;
		dl_data     = '0;
		{boot_done, reset_req, reset_key, power_on} = 4'b0000;
		{vdc_wr, vdc_rd, buzzer, casout, tape_rx}   = 5'b00000;
		vdc_addr    = '0;
		vdc_din     = '0;
		errors      = 0;
		tests_ok    = 0;
		tests_bad   = 0;
		sweep_done  = 1'b0;
		repeat (3) @(negedge F14M);
		rst = 1'b0;
		run_controller();
		run_mux();
		run_audio_mix();
		begin_test();
		measure_density(1'b1, 1'b1, 1'b1);
		measure_density(1'b0, 1'b1, 1'b1);
		end_test("sigma-delta density");
		run_erase();
		$display("tests: %0d ok, %0d failed, %0d errors", tests_ok, tests_bad, errors);
		if (errors == 0 && tests_bad == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	// Full sweep plus margin
	initial begin
		#(WATCHDOG_NS);
		$display("timeout after %0d ns, a test did not finish", WATCHDOG_NS);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
laser_pkg.sv
laser_sys_ctrl.sv
ram_eraser.sv
ram_port_mux.sv
audio_out.sv
laser_glue_top.sv
tb_laser_glue.sv

// ==== Makefile ====
# Verilator build and run of the glue testbench
TOP       ?= tb_laser_glue
LOG       ?= sim.log
VERILATOR ?= verilator
FILELIST  ?= list.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass message"
	@echo "  clean  remove $(OBJDIR) and $(LOG)"
	@echo "Variables: TOP LOG VERILATOR FILELIST OBJDIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Simulation passed" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
